// File: dm_dmi_pkg.sv
package dm_dmi_pkg;

	// ==============================
	// dmi bus widths
	// ==============================
	localparam int dmi_addr_width = 7;
	localparam int dmi_data_width = 32;

	typedef logic [dmi_addr_width-1:0] dmi_addr_t;
	typedef logic [dmi_data_width-1:0] dmi_word_t;

	// ==============================
	// debug register map
	// ==============================
	localparam dmi_addr_t addr_data0        = 7'h04;
	localparam dmi_addr_t addr_dmcontrol    = 7'h10;
	localparam dmi_addr_t addr_dmstatus     = 7'h11;
	localparam dmi_addr_t addr_hartinfo     = 7'h12;
	localparam dmi_addr_t addr_haltsum      = 7'h13;
	localparam dmi_addr_t addr_abstractcs   = 7'h16;
	localparam dmi_addr_t addr_command      = 7'h17;
	localparam dmi_addr_t addr_abstractauto = 7'h18;
	localparam dmi_addr_t addr_progbuf0     = 7'h20;
	localparam dmi_addr_t addr_progbuf1     = 7'h21;

	// reset and fixed register contents
	localparam dmi_word_t data0_reset    = 32'hbabebabe;
	localparam dmi_word_t progbuf_reset  = 32'h00000013; // addi x0,x0,0
	localparam dmi_word_t unmapped_value = 32'hdeaddead;
	localparam dmi_word_t hartinfo_value = 32'h00011043; // dataaccess, datasize 1, dataaddr 0x043
	localparam logic [4:0] progbuf_count = 5'd2;
	localparam logic [4:0] data_count    = 5'd1;
	localparam logic [3:0] dm_version    = 4'd2;    // debug spec 0.13

	// dmcontrol fields
	localparam int dmctl_haltreq_bit   = 31;
	localparam int dmctl_resumereq_bit = 30;
	localparam int dmctl_hartsel_msb   = 25;
	localparam int dmctl_hartsel_lsb   = 16;
	localparam int dmctl_ndmreset_bit  = 1;
	localparam int dmctl_dmactive_bit  = 0;

	// abstractauto fields
	localparam int auto_data0_bit   = 0;
	localparam int auto_progbuf_lsb = 16; // progbuf1 sits one above

endpackage

// File: dm_hart_pkg.sv
package dm_hart_pkg;

	// ==============================
	// hart side widths
	// ==============================
	localparam int xlen           = 32;
	localparam int gpr_addr_width = 5;
	localparam int csr_addr_width = 12;

	typedef logic [xlen-1:0]           xword_t;
	typedef logic [gpr_addr_width-1:0] gpr_addr_t;
	typedef logic [csr_addr_width-1:0] csr_addr_t;
	typedef logic [2:0]                csr_cmd_t;
	typedef logic [2:0]                cmderr_t;

	// csr file commands
	localparam csr_cmd_t csr_idle  = 3'h0;
	localparam csr_cmd_t csr_read  = 3'h4;
	localparam csr_cmd_t csr_write = 3'h5;

	// ==============================
	// abstract command word
	// ==============================
	localparam int cmdtype_msb   = 31;
	localparam int cmdtype_lsb   = 24;
	localparam int aarsize_msb   = 22;
	localparam int aarsize_lsb   = 20;
	localparam int postexec_bit  = 18;
	localparam int transfer_bit  = 17;
	localparam int write_bit     = 16;
	localparam int regno_msb     = 15;
	localparam int regno_lsb     = 0;
	localparam int regno_gpr_bit = 12; // gprs live at 0x1000..0x101f

	localparam logic [7:0] cmd_access_reg = 8'h00;
	localparam logic [2:0] size_32        = 3'd2;

	localparam cmderr_t cmderr_none    = 3'd0;
	localparam cmderr_t cmderr_notsupp = 3'd2;

	// command engine states
	typedef enum logic [2:0] {
		st_idle,
		st_decode,
		st_read,
		st_write,
		st_postexec,
		st_error_notsupp
	} cmd_state_t;

endpackage

// File: dm_cmd_if.sv
`timescale 1ns/1ps

interface dm_cmd_if;
	import dm_hart_pkg::*;

	logic    start;        // launch pulse from register block
	xword_t  command;      // stored command word
	xword_t  data0;        // argument for writes
	logic    busy;         // engine not idle
	logic    result_valid; // load result into data0
	xword_t  result;
	logic    err_valid;    // load err_code into cmderr
	cmderr_t err_code;

	modport regs (
		output start, command, data0,
		input  busy, result_valid, result, err_valid, err_code
	);

	modport engine (
		input  start, command, data0,
		output busy, result_valid, result, err_valid, err_code
	);

endinterface

// File: dmi_transport.sv
`timescale 1ns/1ps

module dmi_transport (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  dmi_en,
	input  logic                  dmi_wen,
	input  dm_dmi_pkg::dmi_addr_t dmi_addr,
	input  dm_dmi_pkg::dmi_word_t dmi_wdata,
	output dm_dmi_pkg::dmi_word_t dmi_rdata,
	output logic                  wr_strobe,
	output logic                  rd_strobe,
	output dm_dmi_pkg::dmi_addr_t reg_addr,
	output dm_dmi_pkg::dmi_word_t reg_wdata,
	input  dm_dmi_pkg::dmi_word_t reg_rdata
);
	import dm_dmi_pkg::*;

	typedef enum logic [1:0] {
		dmi_idle,
		dmi_read,
		dmi_write,
		dmi_wait_end
	} dmi_state_t;

	dmi_state_t state, state_next;
	logic       en_sync1, en_sync2; // two stage enable sync
	logic       wen_r;
	dmi_addr_t  addr_r;
	dmi_word_t  wdata_r;

	// ==============================
	// enable sync and capture
	// ==============================
	always_ff @(posedge clk) begin
		if (reset) begin
			en_sync1 <= 1'b0;
			en_sync2 <= 1'b0;
			wen_r    <= 1'b0;
			state    <= dmi_idle;
		end else begin
			en_sync1 <= dmi_en;
			en_sync2 <= en_sync1;
			state    <= state_next;
			if (en_sync1)
				wen_r <= dmi_wen; // host holds wen stable while enabled
		end
	end

	// address and data only matter once en_sync2 qualifies them
	always_ff @(posedge clk) begin
		if (en_sync1) begin
			addr_r  <= dmi_addr;
			wdata_r <= dmi_wdata;
		end
	end

	// one access per enable pulse, then park until enable drops
	always_comb begin
		state_next = dmi_idle;
		case (state)
			dmi_idle:     state_next = !en_sync2 ? dmi_idle : (wen_r ? dmi_write : dmi_read);
			dmi_read:     state_next = dmi_wait_end;
			dmi_write:    state_next = dmi_wait_end;
			dmi_wait_end: state_next = en_sync2 ? dmi_wait_end : dmi_idle;
			default:      state_next = dmi_idle;
		endcase
	end

	assign rd_strobe = (state == dmi_read);
	assign wr_strobe = (state == dmi_write);
	assign reg_addr  = addr_r;
	assign reg_wdata = wdata_r;

	// read data lands at the end of the read state and holds until the next read
	always_ff @(posedge clk) begin
		if (rd_strobe)
			dmi_rdata <= reg_rdata;
	end

	// capture relies on the host keeping the request steady while enabled
	a_host_stable: assert property (@(posedge clk) disable iff (reset)
		(dmi_en && $past(dmi_en))
		|-> ($stable(dmi_wen) && $stable(dmi_addr) && $stable(dmi_wdata)));

endmodule

// File: dm_registers.sv
`timescale 1ns/1ps

module dm_registers (
	input  logic                  clk,
	input  logic                  reset,
	input  logic                  wr_strobe,
	input  logic                  rd_strobe,
	input  dm_dmi_pkg::dmi_addr_t reg_addr,
	input  dm_dmi_pkg::dmi_word_t reg_wdata,
	output dm_dmi_pkg::dmi_word_t reg_rdata,
	input  logic                  hart_halted,
	input  logic                  hart_resumeack,
	output logic                  haltreq,
	output logic                  resumereq,
	dm_cmd_if.regs                cmd
);
	import dm_dmi_pkg::*;
	import dm_hart_pkg::*;

	// ==============================
	// register storage
	// ==============================
	dmi_word_t data0;
	dmi_word_t command;
	dmi_word_t dmcontrol;
	dmi_word_t abstractauto;
	dmi_word_t progbuf0;
	dmi_word_t progbuf1;
	cmderr_t   cmderr;
	logic      anyhalted;
	logic      anyrunning;

	logic      cs_wr;       // abstractcs write, clears cmderr
	logic      auto_hit;    // access to an autoexec-enabled register
	logic      nonexistent; // hartsel points past hart 0
	dmi_word_t dmstatus;
	dmi_word_t abstractcs;
	dmi_word_t dmcontrol_rd;

	assign cs_wr = wr_strobe && (reg_addr == addr_abstractcs);

	always_ff @(posedge clk) begin
		if (reset) begin
			data0        <= data0_reset;
			command      <= '0;
			dmcontrol    <= '0;
			abstractauto <= '0;
			progbuf0     <= progbuf_reset;
			progbuf1     <= progbuf_reset;
			cmderr       <= cmderr_none;
			anyhalted    <= 1'b0;
			anyrunning   <= 1'b1; // hart comes up running
		end else begin
			anyhalted  <= hart_halted;
			anyrunning <= !hart_halted;

			// drop haltreq once the hart is halted, unless the host writes dmcontrol now
			if (hart_halted && !wr_strobe)
				dmcontrol[dmctl_haltreq_bit] <= 1'b0;

			if (wr_strobe) begin
				case (reg_addr)
					addr_dmcontrol:    dmcontrol    <= reg_wdata;
					addr_command:      command      <= reg_wdata;
					addr_abstractauto: abstractauto <= reg_wdata;
					addr_progbuf0:     progbuf0     <= reg_wdata;
					addr_progbuf1:     progbuf1     <= reg_wdata;
					default:           ;
				endcase
			end

			// host write wins over an engine result in the same cycle
			if (wr_strobe && reg_addr == addr_data0)
				data0 <= reg_wdata;
			else if (cmd.result_valid)
				data0 <= cmd.result;

			if (cs_wr)
				cmderr <= cmderr_none; // write-to-clear
			else if (cmd.err_valid)
				cmderr <= cmd.err_code;
		end
	end

	// ==============================
	// command launch
	// ==============================
	always_comb begin
		case (reg_addr)
			addr_data0:    auto_hit = abstractauto[auto_data0_bit];
			addr_progbuf0: auto_hit = abstractauto[auto_progbuf_lsb];
			addr_progbuf1: auto_hit = abstractauto[auto_progbuf_lsb + 1];
			default:       auto_hit = 1'b0;
		endcase
	end

	assign cmd.start = (wr_strobe && reg_addr == addr_command)
		|| ((wr_strobe || rd_strobe) && auto_hit);
	assign cmd.command = command;
	assign cmd.data0   = data0;

	assign haltreq   = dmcontrol[dmctl_haltreq_bit];
	assign resumereq = dmcontrol[dmctl_resumereq_bit];

	// ==============================
	// read-back
	// ==============================
	assign nonexistent = |dmcontrol[dmctl_hartsel_msb:dmctl_hartsel_lsb];

	// single hart, so every all* flag mirrors its any* flag
	assign dmstatus = {9'h0, 1'b1, 4'h0,       // impebreak at 22, havereset clear
		hart_resumeack, hart_resumeack,
		nonexistent, nonexistent,
		2'b00,                                  // unavail
		anyrunning, anyrunning,
		anyhalted, anyhalted,
		1'b1, 1'b0, 1'b0, 1'b0,                 // authenticated, no devtree
		dm_version};

	assign abstractcs = {3'h0, progbuf_count, 11'h0, cmd.busy, 1'b0, cmderr,
		3'h0, data_count};

	assign dmcontrol_rd = {30'h0, dmcontrol[dmctl_ndmreset_bit],
		dmcontrol[dmctl_dmactive_bit]};

	always_comb begin
		case (reg_addr)
			addr_data0:        reg_rdata = data0;
			addr_dmcontrol:    reg_rdata = dmcontrol_rd;
			addr_dmstatus:     reg_rdata = dmstatus;
			addr_hartinfo:     reg_rdata = hartinfo_value;
			addr_haltsum:      reg_rdata = {31'h0, hart_halted};
			addr_abstractcs:   reg_rdata = abstractcs;
			addr_command:      reg_rdata = command;
			addr_abstractauto: reg_rdata = abstractauto;
			addr_progbuf0:     reg_rdata = progbuf0;
			addr_progbuf1:     reg_rdata = progbuf1;
			default:           reg_rdata = unmapped_value; // hawindow, devtreeaddr land here too
		endcase
	end

	// an engine error always leaves a nonzero cmderr behind
	a_cmderr_set: assert property (@(posedge clk) disable iff (reset)
		(cmd.err_valid && !cs_wr) |=> (cmderr != cmderr_none));

endmodule

// File: abstract_cmd_engine.sv
`timescale 1ns/1ps

module abstract_cmd_engine (
	input  logic                   clk,
	input  logic                   reset,
	output logic                   regfile_wen,
	output dm_hart_pkg::gpr_addr_t regfile_addr,
	output dm_hart_pkg::xword_t    regfile_wd,
	input  dm_hart_pkg::xword_t    regfile_rd,
	output dm_hart_pkg::csr_addr_t csr_addr,
	output dm_hart_pkg::csr_cmd_t  csr_cmd,
	output dm_hart_pkg::xword_t    csr_wdata,
	input  dm_hart_pkg::xword_t    csr_rdata,
	output logic                   postexec_req,
	dm_cmd_if.engine               cmd
);
	import dm_hart_pkg::*;

	cmd_state_t  state, state_next;
	logic [7:0]  cmdtype;
	logic [2:0]  aarsize;
	logic        postexec;
	logic        transfer;
	logic        write;
	logic [15:0] regno;
	logic        gpr_sel; // gpr port when set, csr port otherwise

	// ==============================
	// command word fields
	// ==============================
	assign cmdtype  = cmd.command[cmdtype_msb:cmdtype_lsb];
	assign aarsize  = cmd.command[aarsize_msb:aarsize_lsb];
	assign postexec = cmd.command[postexec_bit];
	assign transfer = cmd.command[transfer_bit];
	assign write    = cmd.command[write_bit];
	assign regno    = cmd.command[regno_msb:regno_lsb];
	assign gpr_sel  = regno[regno_gpr_bit];

	always_ff @(posedge clk) begin
		if (reset)
			state <= st_idle;
		else
			state <= state_next;
	end

	always_comb begin
		state_next = st_idle;
		case (state)
			st_idle: state_next = cmd.start ? st_decode : st_idle; // start ignored unless idle
			st_decode: begin
				if (cmdtype != cmd_access_reg)
					state_next = st_idle;   // other command types silently dropped
				else if (!transfer)
					state_next = postexec ? st_postexec : st_idle;
				else if (aarsize != size_32)
					state_next = st_error_notsupp;
				else
					state_next = write ? st_write : st_read;
			end
			st_read, st_write: state_next = postexec ? st_postexec : st_idle;
			default:           state_next = st_idle; // postexec and error are single cycle
		endcase
	end

	// ==============================
	// hart ports
	// ==============================
	assign regfile_addr = regno[gpr_addr_width-1:0];
	assign csr_addr     = regno[csr_addr_width-1:0];
	assign regfile_wd   = cmd.data0;
	assign csr_wdata    = cmd.data0;
	assign regfile_wen  = (state == st_write) && gpr_sel;

	always_comb begin
		csr_cmd = csr_idle;
		if (state == st_read && !gpr_sel)
			csr_cmd = csr_read;
		else if (state == st_write && !gpr_sel)
			csr_cmd = csr_write;
	end

	assign postexec_req = (state == st_postexec);

	// results back to the register block
	assign cmd.busy         = (state != st_idle);
	assign cmd.result_valid = (state == st_read);
	assign cmd.result       = gpr_sel ? regfile_rd : csr_rdata; // read data is combinational
	assign cmd.err_valid    = (state == st_error_notsupp);
	assign cmd.err_code     = cmd.err_valid ? cmderr_notsupp : cmderr_none;

	// gpr accesses stay inside 0x1000..0x101f, the upper regno bits are not decoded
	a_gpr_range: assert property (@(posedge clk) disable iff (reset)
		((state == st_read || state == st_write) && gpr_sel)
		|-> (regno[regno_msb:gpr_addr_width] == 11'h080));

endmodule

// File: debug_module.sv
`timescale 1ns/1ps

module debug_module (
	input  logic                   clk,
	input  logic                   reset,
	// dmi port
	input  logic                   dmi_en,
	input  logic                   dmi_wen,
	input  dm_dmi_pkg::dmi_addr_t  dmi_addr,
	input  dm_dmi_pkg::dmi_word_t  dmi_wdata,
	output dm_dmi_pkg::dmi_word_t  dmi_rdata,
	// gpr file
	output logic                   regfile_wen,
	output dm_hart_pkg::gpr_addr_t regfile_addr,
	output dm_hart_pkg::xword_t    regfile_wd,
	input  dm_hart_pkg::xword_t    regfile_rd,
	// csr file
	output dm_hart_pkg::csr_addr_t csr_addr,
	output dm_hart_pkg::csr_cmd_t  csr_cmd,
	output dm_hart_pkg::xword_t    csr_wdata,
	input  dm_hart_pkg::xword_t    csr_rdata,
	// run control
	input  logic                   hart_halted,
	input  logic                   hart_resumeack,
	output logic                   haltreq,
	output logic                   resumereq,
	output logic                   postexec_req
);
	import dm_dmi_pkg::*;

	logic      wr_strobe;
	logic      rd_strobe;
	dmi_addr_t reg_addr;
	dmi_word_t reg_wdata;
	dmi_word_t reg_rdata;

	dm_cmd_if cmd_bus (); // registers <-> command engine

	dmi_transport dmi_transport_inst (
		.clk       (clk),
		.reset     (reset),
		.dmi_en    (dmi_en),
		.dmi_wen   (dmi_wen),
		.dmi_addr  (dmi_addr),
		.dmi_wdata (dmi_wdata),
		.dmi_rdata (dmi_rdata),
		.wr_strobe (wr_strobe),
		.rd_strobe (rd_strobe),
		.reg_addr  (reg_addr),
		.reg_wdata (reg_wdata),
		.reg_rdata (reg_rdata)
	);

	dm_registers dm_registers_inst (
		.clk            (clk),
		.reset          (reset),
		.wr_strobe      (wr_strobe),
		.rd_strobe      (rd_strobe),
		.reg_addr       (reg_addr),
		.reg_wdata      (reg_wdata),
		.reg_rdata      (reg_rdata),
		.hart_halted    (hart_halted),
		.hart_resumeack (hart_resumeack),
		.haltreq        (haltreq),
		.resumereq      (resumereq),
		.cmd            (cmd_bus.regs)
	);

	abstract_cmd_engine abstract_cmd_engine_inst (
		.clk          (clk),
		.reset        (reset),
		.regfile_wen  (regfile_wen),
		.regfile_addr (regfile_addr),
		.regfile_wd   (regfile_wd),
		.regfile_rd   (regfile_rd),
		.csr_addr     (csr_addr),
		.csr_cmd      (csr_cmd),
		.csr_wdata    (csr_wdata),
		.csr_rdata    (csr_rdata),
		.postexec_req (postexec_req),
		.cmd          (cmd_bus.engine)
	);

endmodule

// File: tb_debug_module.sv
`timescale 1ns/1ps

module tb_debug_module;
	import dm_dmi_pkg::*;
	import dm_hart_pkg::*;

	// ==============================
	// golden file layout
	// ==============================
	localparam int max_entries          = 64;           // four words per entry
	localparam logic [31:0] op_write    = 32'h0;        // dmi write
	localparam logic [31:0] op_read     = 32'h1;        // dmi read, compare dmi_rdata
	localparam logic [31:0] op_postexec = 32'h2;        // compare postexec pulse count
	localparam logic [31:0] op_haltreq  = 32'h3;        // compare haltreq output level
	localparam logic [31:0] op_end      = 32'hf;

	logic      clk;
	logic      reset;
	logic      dmi_en;
	logic      dmi_wen;
	dmi_addr_t dmi_addr;
	dmi_word_t dmi_wdata;
	dmi_word_t dmi_rdata;
	logic      regfile_wen;
	gpr_addr_t regfile_addr;
	xword_t    regfile_wd;
	xword_t    regfile_rd;
	csr_addr_t csr_addr;
	csr_cmd_t  csr_cmd;
	xword_t    csr_wdata;
	xword_t    csr_rdata;
	logic      hart_halted    = 1'b0;
	logic      hart_resumeack = 1'b0;
	logic      haltreq;
	logic      resumereq;
	logic      postexec_req;

	logic [31:0] golden [0:4*max_entries-1];
	xword_t      gpr [0:31];     // hart register file model
	logic        csr_written;    // one csr entry overridden by a write
	csr_addr_t   csr_wr_addr;
	xword_t      csr_wr_data;
	int          postexec_count;
	int          cycle_count = 0;
	int          cycle_limit;     // set once the golden file is loaded
	int          entry_count;
	int          error_count = 0;
	int          check_count = 0;

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk; // 100 ns period
	end

	debug_module debug_module_inst (
		.clk            (clk),
		.reset          (reset),
		.dmi_en         (dmi_en),
		.dmi_wen        (dmi_wen),
		.dmi_addr       (dmi_addr),
		.dmi_wdata      (dmi_wdata),
		.dmi_rdata      (dmi_rdata),
		.regfile_wen    (regfile_wen),
		.regfile_addr   (regfile_addr),
		.regfile_wd     (regfile_wd),
		.regfile_rd     (regfile_rd),
		.csr_addr       (csr_addr),
		.csr_cmd        (csr_cmd),
		.csr_wdata      (csr_wdata),
		.csr_rdata      (csr_rdata),
		.hart_halted    (hart_halted),
		.hart_resumeack (hart_resumeack),
		.haltreq        (haltreq),
		.resumereq      (resumereq),
		.postexec_req   (postexec_req)
	);

	// ==============================
	// hart model
	// ==============================
	assign regfile_rd = gpr[regfile_addr];                      // combinational read

	always @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				gpr[i] <= i * 32'h01010101;
		end else if (regfile_wen) begin
			gpr[regfile_addr] <= regfile_wd;
		end
	end

	// csr a reads c5000000 + a unless a csr write has replaced it
	always @(posedge clk) begin
		if (reset) begin
			csr_written <= 1'b0;
			csr_wr_addr <= '0;
			csr_wr_data <= '0;
		end else if (csr_cmd == csr_write) begin
			csr_written <= 1'b1;
			csr_wr_addr <= csr_addr;
			csr_wr_data <= csr_wdata;
		end
	end

	// data only comes back while the engine issues a csr read
	always_comb begin
		csr_rdata = '0;
		if (csr_cmd == csr_read)
			csr_rdata = (csr_written && csr_wr_addr == csr_addr) ? csr_wr_data
				: 32'hc5000000 + {20'h0, csr_addr};
	end

	// halt one cycle after haltreq, run one cycle after resumereq
	always @(posedge clk) begin
		if (reset) begin
			hart_halted    <= 1'b0;
			hart_resumeack <= 1'b0;
		end else begin
			if (haltreq)
				hart_halted <= 1'b1;
			else if (resumereq)
				hart_halted <= 1'b0;
			hart_resumeack <= resumereq && hart_halted; // ack only while still halted
		end
	end

	always @(posedge clk) begin
		if (reset)
			postexec_count <= 0;
		else if (postexec_req)
			postexec_count <= postexec_count + 1; // one cycle per postexec state
	end

	// run limit from the golden length
	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= cycle_limit) begin
			$display("Timeout: the golden file did not finish within %0d cycles", cycle_limit);
			$display("Checks failed");
			$finish;
		end
	end

	// ==============================
	// checks and dmi driver
	// ==============================
	task automatic check_value(input string name, input logic [31:0] got,
			input logic [31:0] expected);
		check_count = check_count + 1;
		if (got !== expected) begin
			error_count = error_count + 1;
			$display("Mismatch at %0t: %s = %h, expected %h", $time, name, got, expected);
		end
	endtask

	// enable held for 8 cycles, then low for 4; read data is long settled by the end
	task automatic dmi_transfer(input logic wen, input dmi_addr_t addr, input dmi_word_t wdata);
		@(posedge clk);
		dmi_en    <= 1'b1;
		dmi_wen   <= wen;
		dmi_addr  <= addr;
		dmi_wdata <= wdata;
		repeat (8) @(posedge clk);
		dmi_en <= 1'b0;
		repeat (4) @(posedge clk);
	endtask

	task automatic run_entry(input int idx);
		logic [31:0] op;
		dmi_addr_t   addr;
		dmi_word_t   wdata;
		dmi_word_t   expected;
		op       = golden[4*idx];
		addr     = golden[4*idx+1][dmi_addr_width-1:0];
		wdata    = golden[4*idx+2];
		expected = golden[4*idx+3];
		case (op)
			op_write:    dmi_transfer(1'b1, addr, wdata);
			op_read: begin
				dmi_transfer(1'b0, addr, '0);
				check_value("dmi_rdata", dmi_rdata, expected);
			end
			op_postexec: check_value("postexec_count", postexec_count, expected);
			op_haltreq: begin
				@(posedge clk);
				check_value("haltreq", {31'h0, haltreq}, expected);
			end
			default: begin
				error_count = error_count + 1;
				$display("Golden line %0d has an unknown operation code %h", idx, op);
			end
		endcase
		$display("test %0d finished: op %0h addr %h, %0d errors so far", idx, op, addr,
			error_count);
	endtask

	// ==============================
	// golden file player
	// ==============================
	initial begin
		reset     = 1'b1;
		dmi_en    = 1'b0;
		dmi_wen   = 1'b0;
		dmi_addr  = '0;
		dmi_wdata = '0;
		$readmemh("debug_module_golden.txt", golden);
		entry_count = 0;
		while (entry_count < max_entries && golden[4*entry_count] !== op_end
				&& !$isunknown(golden[4*entry_count]))
			entry_count = entry_count + 1;
		cycle_limit = entry_count * 16 + 100;
		if (entry_count == 0) begin
			error_count = error_count + 1;
			$display("The golden file holds no entries");
		end
		repeat (3) @(posedge clk);
		reset <= 1'b0;
		for (int idx = 0; idx < entry_count; idx++)
			run_entry(idx);
		$display("%0d tests run, %0d checks, %0d errors", entry_count, check_count, error_count);
		if (error_count == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: debug_module_golden.txt
// columns: op addr wdata expected, all hex
// op 0 write, 1 read and compare, 2 postexec count, 3 haltreq level, f end
1 04 00000000 babebabe
1 20 00000000 00000013
1 21 00000000 00000013
1 16 00000000 02000001
1 12 00000000 00011043
0 04 cafef00d 00000000
1 04 00000000 cafef00d
0 20 a5a5a5a5 00000000
1 20 00000000 a5a5a5a5
0 21 5a5a0ff0 00000000
1 21 00000000 5a5a0ff0
1 05 00000000 deaddead
// gpr write x5, gpr read x5, csr read 0x300
0 17 00231005 00000000
0 04 00000000 00000000
0 17 00221005 00000000
1 04 00000000 cafef00d
0 17 00220300 00000000
1 04 00000000 c5000300
// aarsize 3 then clear cmderr
0 17 00320300 00000000
1 16 00000000 02000201
0 16 00000700 00000000
1 16 00000000 02000001
// halt, resume, hartsel 1
0 10 80000001 00000000
1 11 00000000 00400382
3 00 00000000 00000000
1 10 00000000 00000001
0 10 40000001 00000000
1 11 00000000 00400c82
0 10 00010001 00000000
1 11 00000000 0040cc82
// postexec only, then autoexec on data0
0 17 00040000 00000000
2 00 00000000 00000001
0 17 0022100a 00000000
0 04 11111111 00000000
1 04 00000000 11111111
0 18 00000001 00000000
1 18 00000000 00000001
0 04 22222222 00000000
1 04 00000000 0a0a0a0a
2 00 00000000 00000001
f 00 00000000 00000000

// File: verilog.f
dm_dmi_pkg.sv
dm_hart_pkg.sv
dm_cmd_if.sv
dmi_transport.sv
dm_registers.sv
abstract_cmd_engine.sv
debug_module.sv
tb_debug_module.sv

// File: run_sim.sh
#!/bin/sh
# build and run the debug module testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f verilog.f --top-module tb_debug_module
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/Vtb_debug_module)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "All checks passed"; then
	exit 0
fi
exit 1
